//--- pr_pkg.sv
package pr_pkg;

  localparam int data_width = 128;
  localparam int strb_width = data_width / 8;
  localparam int mem_lines  = 256;

  localparam logic [15:0] default_mtu = 16'd1500;

  // Status write codes from the wrapper
  localparam logic [2:0] st_idle     = 3'd0;
  localparam logic [2:0] st_fwd_port = 3'd1;
  localparam logic [2:0] st_mtu      = 3'd2;
  localparam logic [2:0] st_ident    = 3'd3;
  localparam logic [2:0] st_bc_send  = 3'd4;

  // Report codes towards the wrapper
  localparam logic [1:0] rep_desc_in  = 2'd0;
  localparam logic [1:0] rep_desc_out = 2'd1;
  localparam logic [1:0] rep_bc_rx    = 2'd2;
  localparam logic [1:0] rep_bc_last  = 2'd3;

  // Line index sits in addr[11:4]
  typedef struct packed {
    logic [25:0]           addr;
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } dma_wr_cmd_t;

  typedef struct packed {
    logic [25:0] addr;
  } dma_rd_cmd_t;

  typedef struct packed {
    logic [7:0]  tag;
    logic [3:0]  port;
    logic [3:0]  rsvd;
    logic [15:0] len;
    logic [31:0] addr;
  } desc_t;

  typedef struct packed {
    logic  second;
    desc_t desc;
  } out_desc_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  core_id;
    logic [10:0] addr;
  } bc_msg_t;

endpackage

//--- pipe_reg.sv
module pipe_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     srst,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t main_q;
  payload_t skid_q;
  logic     skid_valid_q;
  logic     main_load;

  // Main register may take a new item
  assign main_load = m_ready || !m_valid;
  assign s_ready   = !skid_valid_q;
  assign m_data    = main_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (srst) begin
      m_valid      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      m_valid      <= skid_valid_q || s_valid;
      skid_valid_q <= 1'b0;
    end else if (s_valid && s_ready) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : s_data;
    end else if (s_ready) begin
      skid_q <= s_data;
    end
  end

endmodule

//--- core_mem.sv
module core_mem (
  input  logic                            clk,
  input  logic                            rst_n,
  input  pr_pkg::dma_wr_cmd_t             wr_cmd,
  input  logic                            wr_valid,
  output logic                            wr_ready,
  input  pr_pkg::dma_rd_cmd_t             rd_cmd,
  input  logic                            rd_valid,
  output logic                            rd_ready,
  output logic [pr_pkg::data_width-1:0]   resp_data,
  output logic                            resp_valid,
  input  logic                            resp_ready
);

  logic [pr_pkg::data_width-1:0] mem [0:pr_pkg::mem_lines-1];
  logic [7:0] wr_line;
  logic [7:0] rd_line;
  logic       wr_fire;
  logic       rd_fire;

  assign wr_line = wr_cmd.addr[11:4];
  assign rd_line = rd_cmd.addr[11:4];
  assign wr_fire = wr_valid && wr_ready;

  // Response register is free or draining this cycle
  assign rd_ready = !resp_valid || resp_ready;
  assign rd_fire  = rd_valid && rd_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      wr_ready <= 1'b1;
      if (rd_fire) begin
        resp_valid <= 1'b1;
      end else if (resp_ready) begin
        resp_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Array with byte strobes
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < pr_pkg::strb_width; b++) begin
        if (wr_cmd.strb[b]) begin
          mem[wr_line][8*b +: 8] <= wr_cmd.data[8*b +: 8];
        end
      end
    end
    if (rd_fire) begin
      resp_data <= mem[rd_line];
    end
  end

endmodule

//--- desc_engine.sv
module desc_engine (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              srst,
  input  pr_pkg::desc_t     in_desc,
  input  logic              in_valid,
  output logic              in_ready,
  output pr_pkg::out_desc_t out_desc,
  output logic              out_valid,
  input  logic              out_ready,
  input  logic [3:0]        fwd_port,
  input  logic [15:0]       mtu,
  output logic [31:0]       desc_in_count,
  output logic [31:0]       desc_out_count
);

  pr_pkg::desc_t pend_q;
  logic          pend_valid_q;
  pr_pkg::desc_t fwd_d;
  pr_pkg::desc_t first_d;
  pr_pkg::desc_t second_d;
  logic          split;
  logic          load;
  logic          in_fire;

  assign load     = !out_valid || out_ready;
  assign in_ready = load && !pend_valid_q;
  assign in_fire  = in_valid && in_ready;
  assign split    = fwd_d.len > mtu;

  // Rewritten port, then the two halves of a split
  always_comb begin
    fwd_d         = in_desc;
    fwd_d.port    = fwd_port;
    first_d       = fwd_d;
    first_d.len   = mtu;
    second_d      = fwd_d;
    second_d.len  = fwd_d.len - mtu;
    second_d.addr = fwd_d.addr + {16'h0000, mtu};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid      <= 1'b0;
      pend_valid_q   <= 1'b0;
      desc_in_count  <= '0;
      desc_out_count <= '0;
    end else if (srst) begin
      out_valid      <= 1'b0;
      pend_valid_q   <= 1'b0;
      desc_in_count  <= '0;
      desc_out_count <= '0;
    end else begin
      if (load) begin
        out_valid    <= pend_valid_q || in_fire;
        pend_valid_q <= !pend_valid_q && in_fire && split;
      end
      if (in_fire) begin
        desc_in_count <= desc_in_count + 32'd1;
      end
      if (out_valid && out_ready) begin
        desc_out_count <= desc_out_count + 32'd1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Payload registers
  always_ff @(posedge clk) begin
    if (load) begin
      if (pend_valid_q) begin
        out_desc <= {1'b1, pend_q};
      end else begin
        out_desc <= {1'b0, split ? first_d : fwd_d};
        pend_q   <= second_d;
      end
    end
  end

endmodule

//--- msg_status.sv
module msg_status (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            srst,
  input  logic [2:0]      status_addr,
  input  logic [31:0]     status_data,
  output logic [3:0]      fwd_port,
  output logic [15:0]     mtu,
  input  logic [31:0]     desc_in_count,
  input  logic [31:0]     desc_out_count,
  input  pr_pkg::bc_msg_t bc_in,
  input  logic            bc_in_valid,
  output pr_pkg::bc_msg_t bc_out,
  output logic            bc_out_valid,
  input  logic            bc_out_ready,
  output logic [1:0]      report_addr,
  output logic [31:0]     report_data
);

  logic [3:0]  core_id;
  logic [10:0] bc_addr;
  logic [31:0] bc_rx_count;
  logic [31:0] bc_last;
  logic        rx_hit;
  logic        send_req;
  logic [1:0]  next_addr;
  logic [31:0] rep_value;

  // Own messages are dropped
  assign rx_hit    = bc_in_valid && (bc_in.core_id != core_id);
  assign send_req  = (status_addr == pr_pkg::st_bc_send) && !bc_out_valid;
  assign next_addr = report_addr + 2'd1;

  always_comb begin
    case (next_addr)
      pr_pkg::rep_desc_in:  rep_value = desc_in_count;
      pr_pkg::rep_desc_out: rep_value = desc_out_count;
      pr_pkg::rep_bc_rx:    rep_value = bc_rx_count;
      default:              rep_value = bc_last;
    endcase
  end

  ////////////////////////////////////////////////////
  // Configuration, send flag and report
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fwd_port     <= '0;
      mtu          <= pr_pkg::default_mtu;
      core_id      <= '0;
      bc_addr      <= '0;
      bc_out_valid <= 1'b0;
      report_addr  <= '0;
      report_data  <= '0;
    end else begin
      case (status_addr)
        pr_pkg::st_fwd_port: fwd_port <= status_data[3:0];
        pr_pkg::st_mtu:      mtu <= status_data[15:0];
        pr_pkg::st_ident: begin
          core_id <= status_data[3:0];
          bc_addr <= status_data[14:4];
        end
        default: ;
      endcase
      if (send_req) begin
        bc_out_valid <= 1'b1;
      end else if (bc_out_ready) begin
        bc_out_valid <= 1'b0;
      end
      report_addr <= next_addr;
      report_data <= rep_value;
    end
  end

  // Receive counters follow core reset too
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bc_rx_count <= '0;
      bc_last     <= '0;
    end else if (srst) begin
      bc_rx_count <= '0;
      bc_last     <= '0;
    end else if (rx_hit) begin
      bc_rx_count <= bc_rx_count + 32'd1;
      bc_last     <= bc_in.data;
    end
  end

  always_ff @(posedge clk) begin
    if (send_req) begin
      bc_out <= '{data: status_data, core_id: core_id, addr: bc_addr};
    end
  end

endmodule

//--- pkt_core.sv
module pkt_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          srst,
  input  pr_pkg::dma_wr_cmd_t           mem_wr_cmd,
  input  logic                          mem_wr_valid,
  output logic                          mem_wr_ready,
  input  pr_pkg::dma_rd_cmd_t           mem_rd_cmd,
  input  logic                          mem_rd_valid,
  output logic                          mem_rd_ready,
  output logic [pr_pkg::data_width-1:0] mem_resp_data,
  output logic                          mem_resp_valid,
  input  logic                          mem_resp_ready,
  input  pr_pkg::desc_t                 in_desc,
  input  logic                          in_valid,
  output logic                          in_ready,
  output pr_pkg::out_desc_t             out_desc,
  output logic                          out_valid,
  input  logic                          out_ready,
  input  pr_pkg::bc_msg_t               bc_in,
  input  logic                          bc_in_valid,
  output pr_pkg::bc_msg_t               bc_out,
  output logic                          bc_out_valid,
  input  logic                          bc_out_ready,
  input  logic [2:0]                    status_addr,
  input  logic [31:0]                   status_data,
  output logic [1:0]                    report_addr,
  output logic [31:0]                   report_data
);

  logic [3:0]  fwd_port;
  logic [15:0] mtu;
  logic [31:0] desc_in_count;
  logic [31:0] desc_out_count;

  core_mem mem_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_cmd     (mem_wr_cmd),
    .wr_valid   (mem_wr_valid),
    .wr_ready   (mem_wr_ready),
    .rd_cmd     (mem_rd_cmd),
    .rd_valid   (mem_rd_valid),
    .rd_ready   (mem_rd_ready),
    .resp_data  (mem_resp_data),
    .resp_valid (mem_resp_valid),
    .resp_ready (mem_resp_ready)
  );

  desc_engine desc_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .srst           (srst),
    .in_desc        (in_desc),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .out_desc       (out_desc),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .fwd_port       (fwd_port),
    .mtu            (mtu),
    .desc_in_count  (desc_in_count),
    .desc_out_count (desc_out_count)
  );

  msg_status status_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .srst           (srst),
    .status_addr    (status_addr),
    .status_data    (status_data),
    .fwd_port       (fwd_port),
    .mtu            (mtu),
    .desc_in_count  (desc_in_count),
    .desc_out_count (desc_out_count),
    .bc_in          (bc_in),
    .bc_in_valid    (bc_in_valid),
    .bc_out         (bc_out),
    .bc_out_valid   (bc_out_valid),
    .bc_out_ready   (bc_out_ready),
    .report_addr    (report_addr),
    .report_data    (report_data)
  );

endmodule

//--- pr_boundary.sv
module pr_boundary (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          core_reset,
  input  pr_pkg::dma_wr_cmd_t           dma_wr_cmd,
  input  logic                          dma_cmd_wr_en,
  output logic                          dma_cmd_wr_ready,
  input  pr_pkg::dma_rd_cmd_t           dma_rd_cmd,
  input  logic                          dma_cmd_rd_en,
  output logic                          dma_cmd_rd_ready,
  output logic [pr_pkg::data_width-1:0] dma_rd_resp_data,
  output logic                          dma_rd_resp_valid,
  input  logic                          dma_rd_resp_ready,
  input  pr_pkg::desc_t                 in_desc,
  input  logic                          in_desc_valid,
  output logic                          in_desc_taken,
  output pr_pkg::out_desc_t             out_desc,
  output logic                          out_desc_valid,
  input  logic                          out_desc_ready,
  input  pr_pkg::bc_msg_t               bc_msg_in,
  input  logic                          bc_msg_in_valid,
  output pr_pkg::bc_msg_t               bc_msg_out,
  output logic                          bc_msg_out_valid,
  input  logic                          bc_msg_out_ready,
  input  logic [31:0]                   wrapper_status_data,
  input  logic [2:0]                    wrapper_status_addr,
  output logic [31:0]                   core_status_data,
  output logic [1:0]                    core_status_addr
);

  logic [1:0]  rst_sync_q;
  logic        rst_local_n;
  logic        core_reset_q;
  logic [31:0] status_data_q;
  logic [2:0]  status_addr_q;
  logic [31:0] report_data;
  logic [1:0]  report_addr;

  pr_pkg::dma_wr_cmd_t           wr_cmd_r;
  logic                          wr_valid_r;
  logic                          wr_ready_r;
  pr_pkg::dma_rd_cmd_t           rd_cmd_r;
  logic                          rd_valid_r;
  logic                          rd_ready_r;
  logic [pr_pkg::data_width-1:0] resp_data_n;
  logic                          resp_valid_n;
  logic                          resp_ready_n;
  pr_pkg::desc_t                 in_desc_r;
  logic                          in_valid_r;
  logic                          in_ready_r;
  pr_pkg::out_desc_t             out_desc_n;
  logic                          out_valid_n;
  logic                          out_ready_n;
  pr_pkg::bc_msg_t               bc_in_r;
  logic                          bc_in_valid_r;
  pr_pkg::bc_msg_t               bc_out_n;
  logic                          bc_out_valid_n;
  logic                          bc_out_ready_n;

  ////////////////////////////////////////////////////
  // Resets and status lines
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q   <= 2'b00;
      core_reset_q <= 1'b0;
    end else begin
      rst_sync_q   <= {rst_sync_q[0], 1'b1};
      core_reset_q <= core_reset;
    end
  end

  assign rst_local_n = rst_sync_q[1];

  always_ff @(posedge clk or negedge rst_local_n) begin
    if (!rst_local_n) begin
      status_data_q    <= '0;
      status_addr_q    <= pr_pkg::st_idle;
      core_status_data <= '0;
      core_status_addr <= '0;
    end else begin
      status_data_q    <= wrapper_status_data;
      status_addr_q    <= wrapper_status_addr;
      core_status_data <= report_data;
      core_status_addr <= report_addr;
    end
  end

  ////////////////////////////////////////////////////
  // DMA slices
  pipe_reg #(.payload_t(pr_pkg::dma_wr_cmd_t)) dma_wr_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(1'b0),
    .s_data(dma_wr_cmd), .s_valid(dma_cmd_wr_en), .s_ready(dma_cmd_wr_ready),
    .m_data(wr_cmd_r), .m_valid(wr_valid_r), .m_ready(wr_ready_r)
  );

  pipe_reg #(.payload_t(pr_pkg::dma_rd_cmd_t)) dma_rd_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(1'b0),
    .s_data(dma_rd_cmd), .s_valid(dma_cmd_rd_en), .s_ready(dma_cmd_rd_ready),
    .m_data(rd_cmd_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  pipe_reg #(.payload_t(logic [pr_pkg::data_width-1:0])) dma_resp_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(1'b0),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid),
    .m_ready(dma_rd_resp_ready)
  );

  // Descriptor and broadcast input slices follow core reset
  pipe_reg #(.payload_t(pr_pkg::desc_t)) in_desc_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(core_reset_q),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_valid_r), .m_ready(in_ready_r)
  );

  pipe_reg #(.payload_t(pr_pkg::out_desc_t)) out_desc_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(core_reset_q),
    .s_data(out_desc_n), .s_valid(out_valid_n), .s_ready(out_ready_n),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  // Always drained since the wrapper gives no ready
  pipe_reg #(.payload_t(pr_pkg::bc_msg_t)) bc_in_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(core_reset_q),
    .s_data(bc_msg_in), .s_valid(bc_msg_in_valid), .s_ready(),
    .m_data(bc_in_r), .m_valid(bc_in_valid_r), .m_ready(1'b1)
  );

  pipe_reg #(.payload_t(pr_pkg::bc_msg_t)) bc_out_reg (
    .clk(clk), .rst_n(rst_local_n), .srst(1'b0),
    .s_data(bc_out_n), .s_valid(bc_out_valid_n), .s_ready(bc_out_ready_n),
    .m_data(bc_msg_out), .m_valid(bc_msg_out_valid), .m_ready(bc_msg_out_ready)
  );

  pkt_core core_inst (
    .clk            (clk),
    .rst_n          (rst_local_n),
    .srst           (core_reset_q),
    .mem_wr_cmd     (wr_cmd_r),
    .mem_wr_valid   (wr_valid_r),
    .mem_wr_ready   (wr_ready_r),
    .mem_rd_cmd     (rd_cmd_r),
    .mem_rd_valid   (rd_valid_r),
    .mem_rd_ready   (rd_ready_r),
    .mem_resp_data  (resp_data_n),
    .mem_resp_valid (resp_valid_n),
    .mem_resp_ready (resp_ready_n),
    .in_desc        (in_desc_r),
    .in_valid       (in_valid_r),
    .in_ready       (in_ready_r),
    .out_desc       (out_desc_n),
    .out_valid      (out_valid_n),
    .out_ready      (out_ready_n),
    .bc_in          (bc_in_r),
    .bc_in_valid    (bc_in_valid_r),
    .bc_out         (bc_out_n),
    .bc_out_valid   (bc_out_valid_n),
    .bc_out_ready   (bc_out_ready_n),
    .status_addr    (status_addr_q),
    .status_data    (status_data_q),
    .report_addr    (report_addr),
    .report_data    (report_data)
  );

endmodule

//--- tb_pr_boundary.sv
module tb_pr_boundary;
  timeunit 1ns;
  timeprecision 1ps;

  logic                          clk;
  logic                          rst_n;
  logic                          core_reset;
  pr_pkg::dma_wr_cmd_t           dma_wr_cmd;
  logic                          dma_cmd_wr_en;
  logic                          dma_cmd_wr_ready;
  pr_pkg::dma_rd_cmd_t           dma_rd_cmd;
  logic                          dma_cmd_rd_en;
  logic                          dma_cmd_rd_ready;
  logic [pr_pkg::data_width-1:0] dma_rd_resp_data;
  logic                          dma_rd_resp_valid;
  logic                          dma_rd_resp_ready;
  pr_pkg::desc_t                 in_desc;
  logic                          in_desc_valid;
  logic                          in_desc_taken;
  pr_pkg::out_desc_t             out_desc;
  logic                          out_desc_valid;
  logic                          out_desc_ready;
  pr_pkg::bc_msg_t               bc_msg_in;
  logic                          bc_msg_in_valid;
  pr_pkg::bc_msg_t               bc_msg_out;
  logic                          bc_msg_out_valid;
  logic                          bc_msg_out_ready;
  logic [31:0]                   wrapper_status_data;
  logic [2:0]                    wrapper_status_addr;
  logic [31:0]                   core_status_data;
  logic [1:0]                    core_status_addr;

  integer seed;
  int     cycles;
  int     check_count;
  int     error_count;
  int     test_errors;
  string  test_name;
  logic   stall_on;
  logic   hold_bc;

  pr_pkg::bc_msg_t   last_bc;
  logic [127:0]      model_mem [0:255];
  logic [127:0]      exp_resp [$];
  pr_pkg::out_desc_t exp_desc [$];
  pr_pkg::bc_msg_t   exp_bc [$];
  logic [3:0]        cfg_port;
  logic [15:0]       cfg_mtu;
  logic [3:0]        own_id;
  logic [10:0]       own_addr;
  logic [31:0]       cnt_desc_in;
  logic [31:0]       cnt_desc_out;
  logic [31:0]       cnt_bc_rx;
  logic [31:0]       bc_last;
  logic [31:0]       rep_vals [0:3];

  pr_boundary UUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Every bit of the line index shows up in the fill
  function automatic logic [127:0] fill_line(input logic [7:0] line);
    return {16{line}} ^ {4{32'h9e37_79b9}};
  endfunction

  function automatic logic [127:0] merge_bytes(input logic [127:0] old,
                                               input logic [127:0] data,
                                               input logic [15:0]  strb);
    logic [127:0] res;
    res = old;
    for (int b = 0; b < 16; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic void model_desc(input pr_pkg::desc_t d);
    pr_pkg::out_desc_t o;
    o.second    = 1'b0;
    o.desc      = d;
    o.desc.port = cfg_port;
    cnt_desc_in = cnt_desc_in + 32'd1;
    if (d.len > cfg_mtu) begin
      o.desc.len = cfg_mtu;
      exp_desc.push_back(o);
      cnt_desc_out = cnt_desc_out + 32'd1;
      o.second    = 1'b1;
      o.desc.len  = d.len - cfg_mtu;
      o.desc.addr = d.addr + {16'h0000, cfg_mtu};
    end
    exp_desc.push_back(o);
    cnt_desc_out = cnt_desc_out + 32'd1;
  endfunction

  // Own messages never count
  function automatic void model_bc_rx(input pr_pkg::bc_msg_t m);
    if (m.core_id != own_id) begin
      cnt_bc_rx = cnt_bc_rx + 32'd1;
      bc_last   = m.data;
    end
  endfunction

  //////////////////////////////////////////////////
  // Checks and monitor

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_extra(input string what);
    error_count++;
    test_errors++;
    $display("ERROR at %0t ns: %s came out when none was expected", $time, what);
  endtask

  always @(posedge clk) begin
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      if (exp_resp.size() == 0) begin
        report_extra("read response");
      end else begin
        check_value("read response", dma_rd_resp_data, exp_resp.pop_front());
      end
    end
    if (out_desc_valid && out_desc_ready) begin
      if (exp_desc.size() == 0) begin
        report_extra("output descriptor");
      end else begin
        check_value("output descriptor", 128'(out_desc), 128'(exp_desc.pop_front()));
      end
    end
    if (bc_msg_out_valid && bc_msg_out_ready) begin
      if (exp_bc.size() == 0) begin
        report_extra("broadcast message");
      end else begin
        check_value("broadcast message", 128'(bc_msg_out), 128'(exp_bc.pop_front()));
      end
    end
    // Stalled broadcast must stay put
    if (hold_bc) begin
      check_value("held broadcast valid", 128'(bc_msg_out_valid), 128'd1);
      check_value("held broadcast message", 128'(bc_msg_out), 128'(last_bc));
    end
    hold_bc = bc_msg_out_valid && !bc_msg_out_ready;
    last_bc = bc_msg_out;
  end

  // Limit has a wide margin over the length of all tests together
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("Timeout after %0d cycles while test %s was stalled", cycles, test_name);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Random back-pressure on the response and descriptor outputs
  initial begin
    logic [31:0] r;
    logic        resp_rdy;
    logic        desc_rdy;
    dma_rd_resp_ready = 1'b1;
    out_desc_ready    = 1'b1;
    forever begin
      @(posedge clk);
      r        = rand32();
      resp_rdy = !stall_on || r[0];
      desc_rdy = !stall_on || r[1];
      @(negedge clk);
      dma_rd_resp_ready = resp_rdy;
      out_desc_ready    = desc_rdy;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks entered just after a falling edge

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic dma_write(input logic [7:0] line, input logic [127:0] data,
                           input logic [15:0] strb);
    logic [31:0] r;
    logic        taken;
    r = rand32();
    dma_wr_cmd.addr       = r[25:0];
    dma_wr_cmd.addr[11:4] = line;
    dma_wr_cmd.data       = data;
    dma_wr_cmd.strb       = strb;
    dma_cmd_wr_en         = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      taken = dma_cmd_wr_ready;
      @(negedge clk);
    end
    dma_cmd_wr_en   = 1'b0;
    model_mem[line] = merge_bytes(model_mem[line], data, strb);
  endtask

  task automatic dma_read(input logic [7:0] line);
    logic [31:0] r;
    logic        taken;
    r = rand32();
    dma_rd_cmd.addr       = r[25:0];
    dma_rd_cmd.addr[11:4] = line;
    dma_cmd_rd_en         = 1'b1;
    exp_resp.push_back(model_mem[line]);
    taken = 1'b0;
    while (!taken) begin
      taken = dma_cmd_rd_ready;
      @(negedge clk);
    end
    dma_cmd_rd_en = 1'b0;
  endtask

  task automatic send_desc(input pr_pkg::desc_t d);
    logic taken;
    in_desc       = d;
    in_desc_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      taken = in_desc_taken;
      @(negedge clk);
    end
    in_desc_valid = 1'b0;
    model_desc(d);
  endtask

  task automatic inject_bc(input pr_pkg::bc_msg_t m);
    bc_msg_in       = m;
    bc_msg_in_valid = 1'b1;
    @(negedge clk);
    bc_msg_in_valid = 1'b0;
    model_bc_rx(m);
  endtask

  task automatic status_write(input logic [2:0] code, input logic [31:0] data);
    wrapper_status_addr = code;
    wrapper_status_data = data;
    @(negedge clk);
    wrapper_status_addr = pr_pkg::st_idle;
  endtask

  task automatic wait_drain();
    while (exp_resp.size() + exp_desc.size() + exp_bc.size() != 0) begin
      @(negedge clk);
    end
    idle(8);
  endtask

  // Report rotates through all four codes in four cycles
  task automatic check_report();
    logic [1:0] prev_addr;
    logic [1:0] step_addr;
    idle(6);
    prev_addr = core_status_addr;
    repeat (4) begin
      @(negedge clk);
      step_addr = prev_addr + 2'd1;
      check_value("report address step", 128'(core_status_addr), 128'(step_addr));
      prev_addr = core_status_addr;
      rep_vals[core_status_addr] = core_status_data;
    end
    check_value("descriptors in", 128'(rep_vals[pr_pkg::rep_desc_in]), 128'(cnt_desc_in));
    check_value("descriptors out", 128'(rep_vals[pr_pkg::rep_desc_out]), 128'(cnt_desc_out));
    check_value("broadcasts received", 128'(rep_vals[pr_pkg::rep_bc_rx]), 128'(cnt_bc_rx));
    check_value("last broadcast data", 128'(rep_vals[pr_pkg::rep_bc_last]), 128'(bc_last));
  endtask

  task automatic end_test();
    wait_drain();
    check_report();
    $display("Test %s finished with %0d errors", test_name, test_errors);
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [31:0]     r;
    pr_pkg::desc_t   d;
    pr_pkg::bc_msg_t m;
    logic [7:0]      lines [0:63];
    seed                = 16805;
    cycles              = 0;
    check_count         = 0;
    error_count         = 0;
    test_errors         = 0;
    stall_on            = 1'b0;
    hold_bc             = 1'b0;
    cnt_desc_in         = '0;
    cnt_desc_out        = '0;
    cnt_bc_rx           = '0;
    bc_last             = '0;
    cfg_port            = '0;
    cfg_mtu             = pr_pkg::default_mtu;
    own_id              = '0;
    own_addr            = '0;
    rst_n               = 1'b0;
    core_reset          = 1'b0;
    dma_wr_cmd          = '0;
    dma_cmd_wr_en       = 1'b0;
    dma_rd_cmd          = '0;
    dma_cmd_rd_en       = 1'b0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    bc_msg_in           = '0;
    bc_msg_in_valid     = 1'b0;
    bc_msg_out_ready    = 1'b1;
    wrapper_status_data = '0;
    wrapper_status_addr = pr_pkg::st_idle;

    test_name = "reset";
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("valids after reset",
                128'({dma_rd_resp_valid, out_desc_valid, bc_msg_out_valid}), 128'd0);
    check_value("status after reset", 128'(core_status_data), 128'd0);
    idle(4);
    check_value("readys after reset",
                128'({dma_cmd_wr_ready, dma_cmd_rd_ready, in_desc_taken}), 128'(3'b111));
    end_test();

    test_name = "dma memory";
    for (int i = 0; i < 256; i++) begin
      dma_write(8'(i), fill_line(8'(i)), 16'hffff);
    end
    for (int i = 0; i < 64; i++) begin
      r = rand32();
      lines[i] = r[7:0];
      dma_write(lines[i], {rand32(), rand32(), rand32(), rand32()}, r[23:8]);
    end
    for (int i = 0; i < 64; i++) begin
      dma_read(lines[i]);
    end
    end_test();

    test_name = "read stall";
    stall_on = 1'b1;
    for (int i = 0; i < 64; i++) begin
      r = rand32();
      dma_read(r[7:0]);
    end
    end_test();

    test_name = "descriptors";
    r = rand32();
    cfg_port = r[3:0];
    cfg_mtu  = 16'd1000 + {6'd0, r[13:4]};
    status_write(pr_pkg::st_fwd_port, {28'd0, cfg_port});
    status_write(pr_pkg::st_mtu, {16'd0, cfg_mtu});
    idle(4);
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      d.tag  = r[7:0];
      d.port = r[11:8];
      d.rsvd = r[15:12];
      d.len  = cfg_mtu - 16'd256 + {7'd0, r[24:16]};
      d.addr = rand32();
      // Exactly at the MTU stays whole
      if (i == 0) begin
        d.len = cfg_mtu;
      end
      send_desc(d);
    end
    end_test();
    stall_on = 1'b0;

    test_name = "broadcast";
    r = rand32();
    own_id   = r[3:0];
    own_addr = r[14:4];
    status_write(pr_pkg::st_ident, {17'd0, own_addr, own_id});
    idle(4);
    for (int i = 0; i < 24; i++) begin
      r = rand32();
      m.data    = rand32();
      m.core_id = r[0] ? own_id : r[7:4];
      m.addr    = r[18:8];
      inject_bc(m);
    end
    bc_msg_out_ready = 1'b0;
    r = rand32();
    m.data    = r;
    m.core_id = own_id;
    m.addr    = own_addr;
    exp_bc.push_back(m);
    status_write(pr_pkg::st_bc_send, r);
    idle(10);
    check_value("broadcast valid under stall", 128'(bc_msg_out_valid), 128'd1);
    bc_msg_out_ready = 1'b1;
    idle(2);
    r = rand32();
    m.data = r;
    exp_bc.push_back(m);
    status_write(pr_pkg::st_bc_send, r);
    end_test();

    test_name = "core reset";
    core_reset = 1'b1;
    @(negedge clk);
    core_reset   = 1'b0;
    cnt_desc_in  = '0;
    cnt_desc_out = '0;
    cnt_bc_rx    = '0;
    bc_last      = '0;
    idle(4);
    for (int i = 0; i < 16; i++) begin
      dma_read(lines[i]);
    end
    end_test();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
pr_pkg.sv
pipe_reg.sv
core_mem.sv
desc_engine.sv
msg_status.sv
pkt_core.sv
pr_boundary.sv
tb_pr_boundary.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f list.f --top-module pr_boundary

sim:
	verilator --binary --timing --timescale 1ns/1ps -f list.f \
		--top-module tb_pr_boundary -o tb_sim
	./obj_dir/tb_sim > sim.log
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
